//--- hdl/ps2_host.sv
`timescale 1ns/1ps

module ps2_host
    import ps2_pkg::*;
#(
    parameter int filter_len     = 4,
    parameter int inhibit_cycles = 5000
) (
    input  logic       clk,
    input  logic       rst,
    // processor bus
    input  logic       sel_data,
    input  logic       sel_status,
    input  logic       wr,
    input  logic       rd,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic       rdy,
    // PS/2 lines, outputs pull low when 1
    input  logic       ps2_clk_in,
    input  logic       ps2_data_in,
    output logic       ps2_clk_low,
    output logic       ps2_data_low
);

    logic           data_lvl;
    logic           clk_fall;
    logic           tx_start;
    logic [7:0]     tx_byte;
    logic           rx_clear;
    ps2_rx_result_t rx_result;
    logic           rx_busy;
    logic           rx_hold_clk;
    logic           tx_busy;
    logic           tx_ack;
    logic           tx_clk_low;
    logic           tx_data_low;

    ps2_line_sync #(
        .filter_len (filter_len)
    ) u_line_sync (
        .clk      (clk),
        .rst      (rst),
        .clk_in   (ps2_clk_in),
        .data_in  (ps2_data_in),
        .clk_lvl  (),
        .data_lvl (data_lvl),
        .clk_fall (clk_fall)
    );

    ps2_rx u_rx (
        .clk         (clk),
        .rst         (rst),
        .clk_fall    (clk_fall),
        .data_lvl    (data_lvl),
        .enable      (!tx_busy),  // no receive during a send
        .rx_clear    (rx_clear),
        .rx_result   (rx_result),
        .rx_busy     (rx_busy),
        .rx_hold_clk (rx_hold_clk)
    );

    ps2_tx #(
        .inhibit_cycles (inhibit_cycles)
    ) u_tx (
        .clk         (clk),
        .rst         (rst),
        .tx_start    (tx_start),
        .tx_byte     (tx_byte),
        .clk_fall    (clk_fall),
        .data_lvl    (data_lvl),
        .tx_busy     (tx_busy),
        .tx_ack      (tx_ack),
        .tx_clk_low  (tx_clk_low),
        .tx_data_low (tx_data_low)
    );

    ps2_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .sel_data   (sel_data),
        .sel_status (sel_status),
        .wr         (wr),
        .rd         (rd),
        .wdata      (wdata),
        .rx_result  (rx_result),
        .rx_busy    (rx_busy),
        .tx_busy    (tx_busy),
        .tx_ack     (tx_ack),
        .rdata      (rdata),
        .rdy        (rdy),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .rx_clear   (rx_clear)
    );

    // clock held low by request-to-send or by an unread byte
    assign ps2_clk_low  = tx_clk_low || rx_hold_clk;
    assign ps2_data_low = tx_data_low;

endmodule

//--- hdl/ps2_line_sync.sv
`timescale 1ns/1ps

module ps2_line_sync #(
    parameter int filter_len = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic clk_in,
    input  logic data_in,
    output logic clk_lvl,
    output logic data_lvl,
    output logic clk_fall
);

    localparam int cnt_w = (filter_len > 1) ? $clog2(filter_len) : 1;

    // bit 1 is the PS/2 clock, bit 0 the PS/2 data
    logic [1:0]       sync_a;
    logic [1:0]       sync_b;
    logic [1:0]       lvl_q;
    logic [1:0]       accept;
    logic [cnt_w-1:0] stable_cnt [2];

    // two-flop synchronizer, lines idle high
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_a <= 2'b11;
            sync_b <= 2'b11;
        end else begin
            sync_a <= {clk_in, data_in};
            sync_b <= sync_a;
        end
    end

    // new level taken after filter_len differing samples
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            accept[i] = (sync_b[i] != lvl_q[i]) &&
                        (stable_cnt[i] == cnt_w'(filter_len - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lvl_q    <= 2'b11;
            clk_fall <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (sync_b[i] == lvl_q[i] || accept[i]) begin
                    stable_cnt[i] <= '0;  // glitch or accepted, start over
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
                if (accept[i]) begin
                    lvl_q[i] <= sync_b[i];
                end
            end
            clk_fall <= accept[1] && !sync_b[1];  // same cycle as clk_lvl 1 -> 0
        end
    end

    assign clk_lvl  = lvl_q[1];
    assign data_lvl = lvl_q[0];

endmodule

//--- hdl/ps2_pkg.sv
package ps2_pkg;

    // ==========================================================
    // frame layout
    // ==========================================================

    // start, 8 data, parity, stop
    localparam int unsigned ps2_frame_bits = 11;

    localparam int unsigned ps2_data_bits = 8;   // payload width
    localparam int unsigned ps2_parity_pos = 9;  // index of parity bit in frame

    // ==========================================================
    // status register, read through sel_status
    // ==========================================================

    typedef struct packed {
        logic [4:0] pad;           // reads as zero
        logic       tx_ack;        // device pulled data low in ack slot
        logic       rx_parity_ok;  // last frame had odd parity
        logic       has_data;      // bit 0, byte waiting
    } ps2_status_t;

    // ==========================================================
    // receiver output towards the register block
    // ==========================================================

    typedef struct packed {
        logic [7:0] data;       // last received byte
        logic       parity_ok;  // odd parity check result
        logic       has_data;   // held until software clears it
    } ps2_rx_result_t;

endpackage

//--- hdl/ps2_regs.sv
`timescale 1ns/1ps

module ps2_regs
    import ps2_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           sel_data,
    input  logic           sel_status,
    input  logic           wr,
    input  logic           rd,
    input  logic [7:0]     wdata,
    input  ps2_rx_result_t rx_result,
    input  logic           rx_busy,
    input  logic           tx_busy,
    input  logic           tx_ack,
    output logic [7:0]     rdata,
    output logic           rdy,
    output logic           tx_start,
    output logic [7:0]     tx_byte,
    output logic           rx_clear
);

    ps2_status_t status;
    logic        start_q;
    logic        clear_q;
    logic        frame_active;
    logic        data_wr;
    logic        status_wr;

    // ==========================================================
    // write decode
    // ==========================================================

    // pending start counts as a frame in progress
    assign frame_active = tx_busy || rx_busy || start_q;

    assign data_wr   = wr && sel_data && !frame_active;  // busy write dropped
    assign status_wr = wr && sel_status;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_q <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            start_q <= data_wr;
            clear_q <= status_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            tx_byte <= wdata;
        end
    end

    assign tx_start = start_q;
    assign rx_clear = clear_q;

    // ==========================================================
    // read side
    // ==========================================================

    always_comb begin
        status              = '0;
        status.tx_ack       = tx_ack;
        status.rx_parity_ok = rx_result.parity_ok;
        status.has_data     = rx_result.has_data;
    end

    always_comb begin
        rdata = 8'h00;
        if (rd && sel_data) begin
            rdata = rx_result.data;
        end else if (rd && sel_status) begin
            rdata = status;
        end
    end

    // not selected, or nothing on the wire
    assign rdy = !(sel_data || sel_status) || !frame_active;

endmodule

//--- hdl/ps2_rx.sv
`timescale 1ns/1ps

module ps2_rx
    import ps2_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           clk_fall,
    input  logic           data_lvl,
    input  logic           enable,
    input  logic           rx_clear,
    output ps2_rx_result_t rx_result,
    output logic           rx_busy,
    output logic           rx_hold_clk
);

    logic [ps2_frame_bits-1:0] shift_q;
    logic [ps2_frame_bits-1:0] frame_next;
    logic [3:0]                bit_cnt;
    logic [ps2_data_bits-1:0]  data_q;
    logic                      busy_q;
    logic                      has_data_q;
    logic                      parity_ok_q;
    logic                      sample;
    logic                      last_bit;

    // LSB first, newest bit enters at the top
    assign frame_next = {data_lvl, shift_q[ps2_frame_bits-1:1]};

    // edges are ignored while a byte is held
    assign sample   = clk_fall && enable && !has_data_q;
    assign last_bit = (bit_cnt == 4'(ps2_frame_bits - 1));

    always_ff @(posedge clk) begin
        if (sample) begin
            shift_q <= frame_next;
        end
    end

    // ==========================================================
    // bit counter
    // ==========================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt <= '0;
            busy_q  <= 1'b0;
        end else if (!enable) begin
            bit_cnt <= '0;  // host is sending, drop any partial frame
            busy_q  <= 1'b0;
        end else if (sample) begin
            if (bit_cnt == '0) begin
                if (!data_lvl) begin  // start bit read as 1 aborts
                    bit_cnt <= 4'd1;
                    busy_q  <= 1'b1;
                end
            end else if (last_bit) begin
                bit_cnt <= '0;
                busy_q  <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // ==========================================================
    // frame result
    // ==========================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            has_data_q  <= 1'b0;
            parity_ok_q <= 1'b0;
        end else if (sample && last_bit) begin
            has_data_q  <= 1'b1;
            parity_ok_q <= ^frame_next[ps2_parity_pos:1];  // odd over data and parity
        end else if (rx_clear) begin
            has_data_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sample && last_bit) begin
            data_q <= frame_next[ps2_data_bits:1];
        end
    end

    assign rx_result = '{data: data_q, parity_ok: parity_ok_q, has_data: has_data_q};

    assign rx_busy     = busy_q;
    assign rx_hold_clk = has_data_q;  // inhibit device until byte is read

endmodule

//--- hdl/ps2_tx.sv
`timescale 1ns/1ps

module ps2_tx
    import ps2_pkg::*;
#(
    parameter int inhibit_cycles = 5000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    input  logic       clk_fall,
    input  logic       data_lvl,
    output logic       tx_busy,
    output logic       tx_ack,
    output logic       tx_clk_low,
    output logic       tx_data_low
);

    localparam int inh_w = $clog2(inhibit_cycles + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_inhibit,
        st_shift
    } tx_state_t;

    tx_state_t                 state;
    logic [inh_w-1:0]          inh_cnt;
    logic [3:0]                bit_cnt;
    logic [3:0]                bit_nxt;
    logic [ps2_frame_bits-1:0] frame_q;
    logic                      parity;
    logic                      start_ok;
    logic                      inhibit_done;
    logic                      last_edge;

    assign parity       = ~^tx_byte;  // odd parity
    assign start_ok     = tx_start && (state == st_idle);
    assign bit_nxt      = bit_cnt + 4'd1;
    assign inhibit_done = (inh_cnt == inh_w'(inhibit_cycles - 1));
    assign last_edge    = (bit_cnt == 4'(ps2_frame_bits - 1));

    assign tx_busy = (state != st_idle);

    // stop, parity, data, start
    always_ff @(posedge clk) begin
        if (start_ok) begin
            frame_q <= {1'b1, parity, tx_byte, 1'b0};
        end
    end

    // ==========================================================
    // request-to-send and shift sequence
    // ==========================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            inh_cnt     <= '0;
            bit_cnt     <= '0;
            tx_clk_low  <= 1'b0;
            tx_data_low <= 1'b0;
            tx_ack      <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_ok) begin
                        state      <= st_inhibit;
                        inh_cnt    <= '0;
                        tx_clk_low <= 1'b1;  // hold device clock low
                        tx_ack     <= 1'b0;
                    end
                end

                st_inhibit: begin
                    if (inhibit_done) begin
                        state       <= st_shift;
                        bit_cnt     <= '0;
                        tx_clk_low  <= 1'b0;          // release clock
                        tx_data_low <= !frame_q[0];   // start bit
                    end else begin
                        inh_cnt <= inh_cnt + 1'b1;
                    end
                end

                st_shift: begin
                    if (clk_fall) begin
                        if (last_edge) begin
                            // ack slot, device pulls data low
                            tx_ack      <= !data_lvl;
                            tx_data_low <= 1'b0;
                            state       <= st_idle;
                        end else begin
                            tx_data_low <= !frame_q[bit_nxt];  // stop bit releases line
                            bit_cnt     <= bit_nxt;
                        end
                    end
                end

                default: begin
                    state       <= st_idle;
                    tx_clk_low  <= 1'b0;
                    tx_data_low <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- ps2_host.f
hdl/ps2_pkg.sv
hdl/ps2_line_sync.sv
hdl/ps2_rx.sv
hdl/ps2_tx.sv
hdl/ps2_regs.sv
hdl/ps2_host.sv
sim/ps2_host_assertions.sv
sim/ps2_host_checker.sv
sim/ps2_host_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the PS/2 host testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module ps2_host_tb -f ps2_host.f -o ps2_host_sim &&
./obj_dir/ps2_host_sim | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- sim/ps2_host_assertions.sv
`timescale 1ns/1ps

module ps2_host_assertions (
    input logic clk,
    input logic rst,
    input logic tx_busy,
    input logic tx_start,
    input logic rx_clear,
    input logic ps2_clk_low,
    input logic ps2_data_low
);

    // host drives data only inside a send
    data_low_in_send: assert property (
        @(posedge clk) disable iff (rst) ps2_data_low |-> tx_busy
    ) else $error("ps2_data_low set while tx_busy is low");

    start_clear_apart: assert property (
        @(posedge clk) disable iff (rst) !(tx_start && rx_clear)
    ) else $error("tx_start and rx_clear in the same cycle");

    // clock line free right after reset
    clk_free_after_reset: assert property (
        @(posedge clk) rst |=> !ps2_clk_low
    ) else $error("ps2_clk_low still set one cycle after reset");

endmodule

//--- sim/ps2_host_checker.sv
`timescale 1ns/1ps

module ps2_host_checker
    import ps2_pkg::*;
#(
    parameter int inhibit_cycles = 5000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       sel_data,
    input  logic       sel_status,
    input  logic       wr,
    input  logic       rd,
    input  logic [7:0] wdata,
    input  logic [7:0] rdata,
    input  logic       rdy,
    input  logic       ps2_clk_in,
    input  logic       ps2_data_in,
    input  logic       ps2_clk_low,
    input  logic       ps2_data_low,
    output int         errors
);

    ps2_status_t               st_exp;    // status as decoded from the lines
    logic [7:0]                data_exp;
    logic [7:0]                tx_exp;    // byte of the accepted data write
    logic                      tx_par;    // parity bit expected after tx_exp
    logic [ps2_frame_bits-1:0] rx_bits;
    logic [ps2_frame_bits-1:0] tx_bits;
    logic                      tx_pend;
    logic                      tx_shift;  // host frame on the wire
    logic                      clk_q;
    int                        rx_n;
    int                        tx_n;
    int                        inh_cnt;
    int                        settle;    // cycles since has_data changed

    task automatic report(input string name, input logic [7:0] got, input logic [7:0] want);
        $display("ERROR %s: got %h, expected %h", name, got, want);
        errors++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            st_exp   = '0;
            data_exp = 8'h00;
            tx_pend  = 1'b0;
            tx_shift = 1'b0;
            clk_q    = 1'b1;
            rx_n     = 0;
            tx_n     = 0;
            inh_cnt  = 0;
            settle   = 0;
        end else begin
            // ==========================================================
            // bus side
            // ==========================================================
            if (rd && sel_status && rdata !== st_exp) begin
                report("rdata (status)", rdata, st_exp);
            end
            if (rd && sel_data && rdata !== data_exp) begin
                report("rdata (data)", rdata, data_exp);
            end
            if ((sel_data || sel_status) && tx_pend && rdy !== 1'b0) begin
                report("rdy", 8'(rdy), 8'h00);  // frame in progress
            end
            if (wr && sel_status) begin
                st_exp.has_data = 1'b0;
                settle          = 0;
            end
            if (wr && sel_data && !tx_pend) begin
                tx_pend = 1'b1;  // later writes during the send are dropped
                tx_exp  = wdata;
            end

            // ==========================================================
            // line side
            // ==========================================================
            // device frame, sampled on the falling clock
            if (clk_q && !ps2_clk_in && !ps2_clk_low && !tx_pend &&
                (rx_n > 0 || !ps2_data_in)) begin
                rx_bits = {ps2_data_in, rx_bits[ps2_frame_bits-1:1]};
                rx_n++;
                if (rx_n == ps2_frame_bits) begin
                    data_exp            = rx_bits[8:1];
                    // odd count of ones over data and parity
                    st_exp.rx_parity_ok = ($countones(rx_bits[9:1]) % 2) == 1;
                    st_exp.has_data     = 1'b1;
                    rx_n                = 0;
                    settle              = 0;
                end
            end
            // host frame, sampled on the rising clock
            if (!clk_q && ps2_clk_in && tx_shift) begin
                tx_bits = {ps2_data_in, tx_bits[ps2_frame_bits-1:1]};
                tx_n++;
                if (tx_n == ps2_frame_bits) begin
                    tx_par = ($countones(tx_exp) % 2) == 0;  // makes the ones odd
                    if (tx_bits[7:0] !== tx_exp) begin
                        report("ps2 data bits", tx_bits[7:0], tx_exp);
                    end
                    if (tx_bits[9:8] !== {1'b1, tx_par}) begin
                        report("ps2 parity and stop", 8'(tx_bits[9:8]), 8'({1'b1, tx_par}));
                    end
                    st_exp.tx_ack = !tx_bits[10];  // ack slot
                    tx_pend       = 1'b0;
                    tx_shift      = 1'b0;
                end
            end
            // request-to-send, ended by the start bit
            if (ps2_clk_low) begin
                inh_cnt++;
            end else begin
                if (inh_cnt > 0 && ps2_data_low) begin
                    if (!tx_pend) begin
                        $display("host started a frame without an accepted data write");
                        errors++;
                    end
                    if (inh_cnt != inhibit_cycles) begin
                        report("ps2_clk_low cycles", 8'(inh_cnt), 8'(inhibit_cycles));
                    end
                    tx_shift = 1'b1;
                    tx_n     = 0;
                end
                inh_cnt = 0;
            end
            // device clock held exactly while a byte waits
            settle++;
            if (settle > 12 && !tx_pend && ps2_clk_low !== st_exp.has_data) begin
                report("ps2_clk_low", 8'(ps2_clk_low), 8'(st_exp.has_data));
            end
            clk_q = ps2_clk_in;
        end
    end

endmodule

//--- sim/ps2_host_tb.sv
`timescale 1ns/1ps

module ps2_host_tb;

    localparam int filter_len     = 2;
    localparam int inhibit_cycles = 20;
    localparam int half_period    = 30;  // device clock, in system cycles
    localparam int num_rows       = 8;
    localparam int wait_limit     = 4000;

    typedef struct packed {
        logic       to_device;   // 1 host sends, 0 device sends
        logic [7:0] data;
        logic       bad_parity;  // device flips its parity bit
        logic       give_ack;    // device acks the host frame
    } stim_row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        sel_data;
    logic        sel_status;
    logic        wr;
    logic        rd;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        rdy;
    logic        ps2_clk_low;
    logic        ps2_data_low;
    logic        ps2_clk_in;
    logic        ps2_data_in;
    logic        dev_clk;
    logic        dev_data;
    int          errors;
    int          timeouts;
    logic [31:0] rng;
    stim_row_t   rows [num_rows];

    // open-collector lines
    assign ps2_clk_in  = dev_clk & ~ps2_clk_low;
    assign ps2_data_in = dev_data & ~ps2_data_low;

    always #5 clk = ~clk;

    ps2_host #(
        .filter_len     (filter_len),
        .inhibit_cycles (inhibit_cycles)
    ) DUT (.*);

    ps2_host_checker #(
        .inhibit_cycles (inhibit_cycles)
    ) u_checker (.*);

    bind ps2_host ps2_host_assertions u_assertions (
        .clk          (clk),
        .rst          (rst),
        .tx_busy      (tx_busy),
        .tx_start     (tx_start),
        .rx_clear     (rx_clear),
        .ps2_clk_low  (ps2_clk_low),
        .ps2_data_low (ps2_data_low)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic note_timeout(input string what);
        $display("timeout: %s", what);
        timeouts++;
    endtask

    task automatic cycles(input int n);
        repeat (n) @(posedge clk);
        #1;  // drive just after the edge
    endtask

    task automatic bus_cycle(input logic write, input logic to_data, input logic [7:0] value);
        sel_data   = to_data;
        sel_status = !to_data;
        wr         = write;
        rd         = !write;
        wdata      = value;
        cycles(1);
        sel_data   = 1'b0;
        sel_status = 1'b0;
        wr         = 1'b0;
        rd         = 1'b0;
    endtask

    task automatic wait_ready();
        int t;
        t          = 0;
        sel_status = 1'b1;
        while (!rdy && t < wait_limit) begin
            cycles(1);
            t++;
        end
        if (!rdy) begin
            note_timeout("rdy stayed low after the frame");
        end
        sel_status = 1'b0;
    endtask

    // clock released by the host, and a start bit if asked for
    task automatic wait_clock_free(input logic need_start, input string what);
        int t;
        t = 0;
        while ((ps2_clk_low || (need_start && !ps2_data_low)) && t < wait_limit) begin
            cycles(1);
            t++;
        end
        if (ps2_clk_low || (need_start && !ps2_data_low)) begin
            note_timeout(what);
        end
    endtask

    // ==========================================================
    // device model
    // ==========================================================

    task automatic device_send(input logic [7:0] value, input logic bad_parity);
        logic [10:0] frame;
        int          i;
        frame = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
        wait_clock_free(1'b0, "device found the clock held low");
        for (i = 0; i < 11; i++) begin
            dev_data = frame[i];
            cycles(half_period / 2);
            dev_clk = 1'b0;
            cycles(half_period);
            dev_clk = 1'b1;  // line stays low once the host holds it
            cycles(half_period / 2);
        end
        dev_data = 1'b1;
    endtask

    task automatic device_receive(input logic give_ack);
        int i;
        wait_clock_free(1'b1, "host sent no start bit");
        for (i = 1; i <= 11; i++) begin
            if (i == 11) begin
                cycles(half_period / 2);
                dev_data = !give_ack;  // ack slot, after the stop bit
                cycles(half_period / 2);
            end else begin
                cycles(half_period);
            end
            dev_clk = 1'b0;
            cycles(half_period);
            dev_clk = 1'b1;
        end
        cycles(half_period / 2);
        dev_data = 1'b1;
    endtask

    // ==========================================================
    // stimulus table and main loop
    // ==========================================================

    initial begin
        int r;
        rst        = 1'b1;
        sel_data   = 1'b0;
        sel_status = 1'b0;
        wr         = 1'b0;
        rd         = 1'b0;
        wdata      = 8'h00;
        dev_clk    = 1'b1;
        dev_data   = 1'b1;
        timeouts   = 0;
        rng        = 32'd96;
        rows[0] = '{1'b0, 8'hA5, 1'b0, 1'b0};  // good device frame
        rows[1] = '{1'b0, 8'h3C, 1'b1, 1'b0};  // wrong parity
        rows[2] = '{1'b1, 8'h5A, 1'b0, 1'b1};  // acked send
        rows[3] = '{1'b1, 8'hC3, 1'b0, 1'b0};  // no ack
        for (r = 4; r < num_rows; r++) begin
            rng     = next_random(rng);
            rows[r] = '{r[0], rng[15:8], rng[3], rng[4]};
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        cycles(5);
        for (r = 0; r < num_rows && timeouts == 0; r++) begin
            if (rows[r].to_device) begin
                bus_cycle(1'b1, 1'b1, rows[r].data);
                fork
                    device_receive(rows[r].give_ack);
                    begin
                        cycles(5);
                        bus_cycle(1'b1, 1'b1, ~rows[r].data);  // must be dropped
                    end
                join
                wait_ready();
                bus_cycle(1'b0, 1'b0, 8'h00);  // status with tx_ack
            end else begin
                device_send(rows[r].data, rows[r].bad_parity);
                wait_ready();
                bus_cycle(1'b0, 1'b0, 8'h00);
                bus_cycle(1'b0, 1'b1, 8'h00);
                cycles(20);                    // clock held while the byte waits
                bus_cycle(1'b1, 1'b0, 8'h00);  // clear has_data
                cycles(10);
                bus_cycle(1'b0, 1'b0, 8'h00);
            end
        end
        cycles(20);
        $display("rows: %0d, errors: %0d, timeouts: %0d", num_rows, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
